// ==== all.f ====
hdl/ref_mem_pkg.sv
hdl/ref_phase_ctrl.sv
hdl/preload_addr_gen.sv
hdl/search_scan_gen.sv
hdl/bank_addr_mux.sv
hdl/ref_mem_ctrl.sv
+incdir+include
tb/tb_ref_mem_ctrl.sv

// ==== hdl/bank_addr_mux.sv ====
`timescale 1ns/100ps

module bank_addr_mux
	import ref_mem_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       pre_wr_vld,
	input  logic       prime_vld,
	input  logic       scan_vld,
	input  logic       done_pulse,
	input  bank_mask_t wr_grp_mask,
	input  row_addr_t  wr_row,
	input  row_addr_t  prime_row,
	input  row_addr_t  scan_base,
	input  split_t     scan_split,
	output bank_mask_t bank_sel,
	output row_addr_t  wr_addr,
	output logic       rd_en,
	output logic       done,
	output bank_rows_t rd_addr_all,
	output split_t     shift_value
);

	row_addr_t  scan_hi;
	bank_rows_t rows_nxt;

	// lower banks look one pair further down
	assign scan_hi = scan_base + row_addr_t'(ROWS_PER_PAIR);

	always_comb begin
		rows_nxt = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (scan_vld) begin
				if (b < int'(scan_split)) begin
					rows_nxt[b] = scan_hi;
				end else begin
					rows_nxt[b] = scan_base;
				end
			end else if (prime_vld) begin
				// priming reads hit the same row everywhere
				rows_nxt[b] = prime_row;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bank_sel    <= '0;
			wr_addr     <= '0;
			rd_en       <= 1'b0;
			done        <= 1'b0;
			rd_addr_all <= '0;
			shift_value <= '0;
		end else begin
			bank_sel    <= pre_wr_vld ? wr_grp_mask : '0;
			wr_addr     <= pre_wr_vld ? wr_row : '0;
			rd_en       <= prime_vld || scan_vld;
			done        <= done_pulse;
			rd_addr_all <= rows_nxt;
			shift_value <= scan_vld ? scan_split : '0;
		end
	end

endmodule

// ==== hdl/preload_addr_gen.sv ====
`timescale 1ns/100ps

module preload_addr_gen
	import ref_mem_pkg::*;
#(
	parameter int ROWS_PER_GROUP = ref_mem_pkg::ROWS_PER_GROUP
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       preload_go,
	output logic       pre_wr_vld,
	output logic       prime_vld,
	output logic       preload_last,
	output bank_mask_t wr_grp_mask,
	output row_addr_t  wr_row,
	output row_addr_t  prime_row
);

	localparam int NUM_GROUPS = NUM_BANKS / BANKS_PER_GROUP;
	localparam int GRP_W      = (NUM_GROUPS > 1) ? $clog2(NUM_GROUPS) : 1;

	localparam logic [GRP_W-1:0] LAST_GRP = GRP_W'(NUM_GROUPS - 1);
	localparam row_addr_t LAST_ROW    = row_addr_t'(ROWS_PER_GROUP - 1);
	localparam row_addr_t FIRST_PRIME = row_addr_t'(ROWS_PER_GROUP - PRIME_ROWS);
	localparam bank_mask_t GRP_MASK   = bank_mask_t'((1 << BANKS_PER_GROUP) - 1);

	logic [GRP_W-1:0] grp_cnt;
	row_addr_t        row_cnt;
	logic             row_wrap;
	logic             last_grp;

	assign row_wrap = (row_cnt == LAST_ROW);
	assign last_grp = (grp_cnt == LAST_GRP);

	// row inside group, then next group
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grp_cnt <= '0;
			row_cnt <= '0;
		end else if (preload_go) begin
			if (row_wrap) begin
				row_cnt <= '0;
				if (last_grp) begin
					grp_cnt <= '0;
				end else begin
					grp_cnt <= grp_cnt + 1'b1;
				end
			end else begin
				row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	assign pre_wr_vld = preload_go;
	assign wr_row     = row_cnt;

	// four adjacent banks per group
	assign wr_grp_mask = GRP_MASK << (grp_cnt * BANKS_PER_GROUP);

	// tail of the last group primes the first search point
	assign prime_vld = preload_go && last_grp && (row_cnt >= FIRST_PRIME);
	assign prime_row = row_cnt - FIRST_PRIME;

	assign preload_last = preload_go && last_grp && row_wrap;

endmodule

// ==== hdl/ref_mem_ctrl.sv ====
`timescale 1ns/100ps

module ref_mem_ctrl
	import ref_mem_pkg::*;
#(
	parameter int SEARCH_COLS    = ref_mem_pkg::SEARCH_COLS,
	parameter int ROWS_PER_GROUP = ref_mem_pkg::ROWS_PER_GROUP
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       begin_prepare,
	output bank_mask_t bank_sel,
	output row_addr_t  wr_addr,
	output logic       rd_en,
	output bank_rows_t rd_addr_all,
	output split_t     shift_value,
	output logic       done
);

	logic       preload_go;
	logic       search_go;
	logic       done_pulse;
	logic       pre_wr_vld;
	logic       prime_vld;
	logic       preload_last;
	bank_mask_t wr_grp_mask;
	row_addr_t  wr_row;
	row_addr_t  prime_row;
	logic       scan_vld;
	logic       scan_last;
	row_addr_t  scan_base;
	split_t     scan_split;

	ref_phase_ctrl i_phase_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.begin_prepare(begin_prepare),
		.preload_last (preload_last),
		.scan_last    (scan_last),
		.preload_go   (preload_go),
		.search_go    (search_go),
		.done_pulse   (done_pulse)
	);

	preload_addr_gen #(
		.ROWS_PER_GROUP(ROWS_PER_GROUP)
	) i_preload_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.preload_go  (preload_go),
		.pre_wr_vld  (pre_wr_vld),
		.prime_vld   (prime_vld),
		.preload_last(preload_last),
		.wr_grp_mask (wr_grp_mask),
		.wr_row      (wr_row),
		.prime_row   (prime_row)
	);

	search_scan_gen #(
		.SEARCH_COLS(SEARCH_COLS)
	) i_scan_gen (
		.clk       (clk),
		.rst_n     (rst_n),
		.search_go (search_go),
		.scan_vld  (scan_vld),
		.scan_last (scan_last),
		.scan_base (scan_base),
		.scan_split(scan_split)
	);

	bank_addr_mux i_addr_mux (
		.clk        (clk),
		.rst_n      (rst_n),
		.pre_wr_vld (pre_wr_vld),
		.prime_vld  (prime_vld),
		.scan_vld   (scan_vld),
		.done_pulse (done_pulse),
		.wr_grp_mask(wr_grp_mask),
		.wr_row     (wr_row),
		.prime_row  (prime_row),
		.scan_base  (scan_base),
		.scan_split (scan_split),
		.bank_sel   (bank_sel),
		.wr_addr    (wr_addr),
		.rd_en      (rd_en),
		.done       (done),
		.rd_addr_all(rd_addr_all),
		.shift_value(shift_value)
	);

endmodule

// ==== hdl/ref_mem_pkg.sv ====
package ref_mem_pkg;

	// reference buffer geometry
	localparam int NUM_BANKS       = 32;
	localparam int BANKS_PER_GROUP = 4;
	localparam int ROWS_PER_GROUP  = 96;
	localparam int PRIME_ROWS      = 4;

	// search scan shape
	localparam int SEARCH_COLS   = 7;
	localparam int ROWS_PER_PAIR = 24;
	localparam int STALL_FIRST   = 7;
	localparam int STALL_LAST    = 19;
	localparam int SPLIT_STEP    = 8;

	localparam int ROW_W   = 7;
	localparam int SPLIT_W = 5;

	// row address inside one bank
	typedef logic [ROW_W-1:0] row_addr_t;

	// one bit per bank
	typedef logic [NUM_BANKS-1:0] bank_mask_t;

	// bank 0 sits at the low end
	typedef row_addr_t [NUM_BANKS-1:0] bank_rows_t;

	// split index that doubles as shift amount
	typedef logic [SPLIT_W-1:0] split_t;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_PRELOAD,
		PH_SEARCH,
		PH_DONE
	} phase_t;

endpackage

// ==== hdl/ref_phase_ctrl.sv ====
`timescale 1ns/100ps

module ref_phase_ctrl
	import ref_mem_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic begin_prepare,
	input  logic preload_last,
	input  logic scan_last,
	output logic preload_go,
	output logic search_go,
	output logic done_pulse
);

	phase_t phase;
	phase_t phase_nxt;

	always_comb begin
		phase_nxt = phase;
		case (phase)
			PH_IDLE: begin
				// start is only looked at here
				if (begin_prepare) begin
					phase_nxt = PH_PRELOAD;
				end
			end
			PH_PRELOAD: begin
				if (preload_last) begin
					phase_nxt = PH_SEARCH;
				end
			end
			PH_SEARCH: begin
				if (scan_last) begin
					phase_nxt = PH_DONE;
				end
			end
			PH_DONE: begin
				// single cycle
				phase_nxt = PH_IDLE;
			end
			default: begin
				phase_nxt = PH_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
		end else begin
			phase <= phase_nxt;
		end
	end

	assign preload_go = (phase == PH_PRELOAD);
	assign search_go  = (phase == PH_SEARCH);
	assign done_pulse = (phase == PH_DONE);

endmodule

// ==== hdl/search_scan_gen.sv ====
`timescale 1ns/100ps

module search_scan_gen
	import ref_mem_pkg::*;
#(
	parameter int SEARCH_COLS = ref_mem_pkg::SEARCH_COLS
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      search_go,
	output logic      scan_vld,
	output logic      scan_last,
	output row_addr_t scan_base,
	output split_t    scan_split
);

	localparam int COL_W = (SEARCH_COLS > 1) ? $clog2(SEARCH_COLS) : 1;
	localparam int RCW   = $clog2(ROWS_PER_PAIR);

	localparam logic [COL_W-1:0] LAST_COL = COL_W'(SEARCH_COLS - 1);
	localparam logic [RCW-1:0]   LAST_ROW = RCW'(ROWS_PER_PAIR - 1);
	localparam row_addr_t        PAIR_OFF = row_addr_t'(ROWS_PER_PAIR);

	logic [COL_W-1:0] col_cnt;
	logic             pair_cnt;
	logic [RCW-1:0]   row_cnt;
	logic             stall;
	logic             in_stall;
	logic             row_step;
	logic             pair_end;
	row_addr_t        col_base;
	logic [1:0]       col_phase;

	assign in_stall = (row_cnt >= RCW'(STALL_FIRST)) && (row_cnt <= RCW'(STALL_LAST));

	// counter holds on the first issue of a reused row
	assign row_step = !in_stall || stall;
	assign pair_end = pair_cnt && (row_cnt == LAST_ROW);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_cnt  <= '0;
			pair_cnt <= 1'b0;
			row_cnt  <= '0;
			stall    <= 1'b0;
		end else if (search_go) begin
			if (!row_step) begin
				stall <= 1'b1;
			end else begin
				stall <= 1'b0;
				if (row_cnt == LAST_ROW) begin
					row_cnt  <= '0;
					pair_cnt <= ~pair_cnt;
				end else begin
					row_cnt <= row_cnt + 1'b1;
				end
				if (pair_end) begin
					if (col_cnt == LAST_COL) begin
						col_cnt <= '0;
					end else begin
						col_cnt <= col_cnt + 1'b1;
					end
				end
			end
		end
	end

	// every fourth column drops one pair height
	assign col_base  = PAIR_OFF * row_addr_t'(col_cnt >> 2);
	assign col_phase = 2'(col_cnt % 4);

	assign scan_base  = col_base + (pair_cnt ? PAIR_OFF : '0) + row_addr_t'(row_cnt);
	assign scan_split = split_t'(SPLIT_STEP * col_phase);

	assign scan_vld  = search_go;
	assign scan_last = search_go && pair_end && (col_cnt == LAST_COL);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_ref_mem_ctrl -o tb_sim

sim_out=$(./obj_dir/tb_sim 2>&1) || true
echo "$sim_out"

if grep -q "^all tests passed$" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi

// ==== include/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int NUM_STALL  = STALL_LAST - STALL_FIRST + 1;
localparam int PAIR_READS = ROWS_PER_PAIR + NUM_STALL;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	return x;
endfunction

// four adjacent banks in group k / 96
function automatic bank_mask_t write_mask_at(input int k);
	bank_mask_t m;
	m = '0;
	for (int b = 0; b < BANKS_PER_GROUP; b++) begin
		m[(k / ROWS_PER_GROUP) * BANKS_PER_GROUP + b] = 1'b1;
	end
	return m;
endfunction

function automatic row_addr_t write_row_at(input int k);
	return row_addr_t'(k % ROWS_PER_GROUP);
endfunction

// search read n (priming reads excluded) to base row and split
function automatic void scan_point(input int n, output int base, output int split);
	int pair_idx;
	int j;
	int r;
	int col;
	pair_idx = n / PAIR_READS;
	j = n % PAIR_READS;
	if (j < STALL_FIRST) begin
		r = j;
	end else if (j < STALL_FIRST + 2 * NUM_STALL) begin
		// reused rows come twice
		r = STALL_FIRST + (j - STALL_FIRST) / 2;
	end else begin
		r = j - NUM_STALL;
	end
	col = pair_idx / 2;
	base = ROWS_PER_PAIR * (col / 4) + ROWS_PER_PAIR * (pair_idx % 2) + r;
	split = SPLIT_STEP * (col % 4);
endfunction

// read n counts priming reads first
function automatic bank_rows_t read_rows_at(input int n);
	bank_rows_t rows;
	int base;
	int split;
	rows = '0;
	if (n < PRIME_ROWS) begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			rows[b] = row_addr_t'(n);
		end
	end else begin
		scan_point(n - PRIME_ROWS, base, split);
		for (int b = 0; b < NUM_BANKS; b++) begin
			rows[b] = (b < split) ? row_addr_t'(base + ROWS_PER_PAIR) : row_addr_t'(base);
		end
	end
	return rows;
endfunction

function automatic split_t shift_at(input int n);
	int base;
	int split;
	if (n < PRIME_ROWS) begin
		return '0;
	end
	scan_point(n - PRIME_ROWS, base, split);
	return split_t'(split);
endfunction

`endif

// ==== tb/tb_ref_mem_ctrl.sv ====
`timescale 1ns/100ps

module tb_ref_mem_ctrl
	import ref_mem_pkg::*;
();

	logic       clk;
	logic       rst_n;
	logic       begin_prepare;
	bank_mask_t bank_sel;
	row_addr_t  wr_addr;
	logic       rd_en;
	bank_rows_t rd_addr_all;
	split_t     shift_value;
	logic       done;
	logic [31:0] rng_state;

	`include "tb_ref_model.svh"

	localparam int TOTAL_WRITES = (NUM_BANKS / BANKS_PER_GROUP) * ROWS_PER_GROUP;
	localparam int TOTAL_READS  = PRIME_ROWS + SEARCH_COLS * 2 * PAIR_READS;
	localparam int FIRST_PRIME  = TOTAL_WRITES - PRIME_ROWS;

	ref_mem_ctrl #(
		.SEARCH_COLS   (SEARCH_COLS),
		.ROWS_PER_GROUP(ROWS_PER_GROUP)
	) i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.begin_prepare(begin_prepare),
		.bank_sel     (bank_sel),
		.wr_addr      (wr_addr),
		.rd_en        (rd_en),
		.rd_addr_all  (rd_addr_all),
		.shift_value  (shift_value),
		.done         (done)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [255:0] actual,
			input logic [255:0] expected);
		if (actual !== expected) begin
			$display("FAIL time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
			$display("tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic expect_quiet();
		check_value("bank_sel", 256'(bank_sel), 256'(0));
		check_value("wr_addr", 256'(wr_addr), 256'(0));
		check_value("rd_en", 256'(rd_en), 256'(0));
		check_value("rd_addr_all", 256'(rd_addr_all), 256'(0));
		check_value("shift_value", 256'(shift_value), 256'(0));
		check_value("done", 256'(done), 256'(0));
	endtask

	task automatic idle_gap();
		int gap;
		rng_state = xorshift32(rng_state);
		gap = 4 + int'(rng_state % 16);
		repeat (gap) begin
			@(negedge clk);
			expect_quiet();
		end
	endtask

	task automatic pulse_start();
		@(posedge clk);
		#2 begin_prepare = 1'b1;
		@(posedge clk);
		#2 begin_prepare = 1'b0;
	endtask

	// ends on the sample of the first search read
	task automatic run_preload(input bit poke_start);
		int waited;
		waited = 0;
		@(negedge clk);
		while (bank_sel == '0) begin
			expect_quiet();
			waited++;
			if (waited > 8) begin
				$display("no preload write appeared after the start pulse");
				$display("tests failed");
				$fatal(1, "timeout");
			end
			@(negedge clk);
		end
		for (int k = 0; k < TOTAL_WRITES; k++) begin
			check_value("bank_sel", 256'(bank_sel), 256'(write_mask_at(k)));
			check_value("wr_addr", 256'(wr_addr), 256'(write_row_at(k)));
			check_value("done", 256'(done), 256'(0));
			check_value("shift_value", 256'(shift_value), 256'(0));
			if (k >= FIRST_PRIME) begin
				check_value("rd_en", 256'(rd_en), 256'(1));
				check_value("rd_addr_all", 256'(rd_addr_all),
					256'(read_rows_at(k - FIRST_PRIME)));
			end else begin
				check_value("rd_en", 256'(rd_en), 256'(0));
				check_value("rd_addr_all", 256'(rd_addr_all), 256'(0));
			end
			// a start during preload must be ignored
			if (poke_start && (k == 300 || k == 301)) begin
				@(posedge clk);
				#2 begin_prepare = (k == 300);
			end
			@(negedge clk);
		end
	endtask

	task automatic run_search();
		for (int n = PRIME_ROWS; n < TOTAL_READS; n++) begin
			check_value("bank_sel", 256'(bank_sel), 256'(0));
			check_value("wr_addr", 256'(wr_addr), 256'(0));
			check_value("rd_en", 256'(rd_en), 256'(1));
			check_value("rd_addr_all", 256'(rd_addr_all), 256'(read_rows_at(n)));
			check_value("shift_value", 256'(shift_value), 256'(shift_at(n)));
			check_value("done", 256'(done), 256'(0));
			@(negedge clk);
		end
	endtask

	task automatic check_done_pulse();
		check_value("done", 256'(done), 256'(1));
		check_value("rd_en", 256'(rd_en), 256'(0));
		check_value("bank_sel", 256'(bank_sel), 256'(0));
		check_value("wr_addr", 256'(wr_addr), 256'(0));
		check_value("rd_addr_all", 256'(rd_addr_all), 256'(0));
		check_value("shift_value", 256'(shift_value), 256'(0));
		repeat (6) begin
			@(negedge clk);
			expect_quiet();
		end
	endtask

	task automatic quiet_after_reset();
		expect_quiet();
		idle_gap();
	endtask

	task automatic full_run_with_ignored_start();
		pulse_start();
		run_preload(1'b1);
		run_search();
		check_done_pulse();
	endtask

	task automatic restart_run();
		idle_gap();
		pulse_start();
		run_preload(1'b0);
		run_search();
		check_done_pulse();
	endtask

	initial begin
		rng_state = 32'h1e7a928d;
		rst_n = 1'b0;
		begin_prepare = 1'b0;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
		@(negedge clk);
		quiet_after_reset();
		full_run_with_ignored_start();
		restart_run();
		$display("all tests passed");
		$finish;
	end

endmodule
